// ==== logic/buf_exchange_pkg.sv ====
// buffer exchange package
// sizes, constants and packed bus types shared by the c-bus side,
// the channel buffers and the read-back mux
`default_nettype none

package buf_exchange_pkg;

    // --------------------
    // sizes
    // --------------------
    // six C-Link channels, each with a downlink and an uplink buffer
    localparam int NUM_CH     = 6;
    // buffer byte width
    localparam int DATA_W     = 8;
    // 2048 deep buffers
    localparam int BUF_ADDR_W = 11;
    // c-bus sees only the lower 1024 bytes
    localparam int CB_OFS_W   = 10;
    // addr reg + data reg in the buffer
    localparam int RD_LAT     = 2;

    // --------------------
    // basic types
    // --------------------
    typedef logic [DATA_W-1:0]     byte_t;
    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
    // one bit per channel, one-hot when valid
    typedef logic [NUM_CH-1:0]     ch_sel_t;

    // --------------------
    // bus words
    // --------------------
    // c-bus buffer address, select in [15:10], offset in [9:0]
    typedef struct packed {
        ch_sel_t               ch_sel;
        logic [CB_OFS_W-1:0]   offset;
    } cb_addr_t;

    // c-bus write, wren is a single-cycle strobe
    typedef struct packed {
        logic     wren;
        cb_addr_t addr;
        byte_t    data;
    } cb_wr_t;

    // c-bus read request, rden is a single-cycle strobe
    typedef struct packed {
        logic     rden;
        cb_addr_t addr;
    } cb_rd_t;

    // buffer write port
    // channel uplink writes and the RAM write ports both use this
    typedef struct packed {
        logic      wren;
        buf_addr_t addr;
        byte_t     data;
    } buf_wr_t;

endpackage

`default_nettype wire

// ==== logic/cbus_buf_ctrl.sv ====
// c-bus buffer controller
// gates c-bus strobes with init done, checks the channel select is
// one-hot, builds the downlink write port and the shared uplink read
// address, and delays the read select to match the buffer latency.
// a bad select gives a registered one-cycle error pulse
`default_nettype none

module cbus_buf_ctrl
(
    input  wire                             sys_clk_50m,
    input  wire                             i_rst_n,
    input  wire logic                       i_init_done,
    input  wire buf_exchange_pkg::cb_wr_t   i_cb_wr,
    input  wire buf_exchange_pkg::cb_rd_t   i_cb_rd,
    output buf_exchange_pkg::buf_wr_t       o_dn_wr,
    output buf_exchange_pkg::ch_sel_t       o_dn_wsel,
    output buf_exchange_pkg::buf_addr_t     o_up_raddr,
    output buf_exchange_pkg::ch_sel_t       o_rd_sel,
    output logic                            o_cb_rvalid,
    output logic                            o_sel_err
);

    import buf_exchange_pkg::*;

    // gated strobes
    logic    wr_go;
    logic    rd_go;
    // strobes with a clean one-hot select
    logic    wr_ok;
    logic    rd_ok;
    // any gated strobe with a bad select
    logic    sel_bad;

    // read select / valid pipeline, index 0 is the first stage
    ch_sel_t rd_sel_q [RD_LAT];
    logic    rd_vld_q [RD_LAT];

    // exactly one bit set
    function automatic logic is_onehot(input ch_sel_t sel);
        ch_sel_t low_cleared;
        low_cleared = sel & (sel - 1'b1);
        return (sel != '0) && (low_cleared == '0);
    endfunction

    // --------------------
    // strobe gating and select check
    // --------------------
    always_comb
    begin
        // nothing gets through before init is done
        wr_go   = i_init_done & i_cb_wr.wren;
        rd_go   = i_init_done & i_cb_rd.rden;

        wr_ok   = wr_go & is_onehot(i_cb_wr.addr.ch_sel);
        rd_ok   = rd_go & is_onehot(i_cb_rd.addr.ch_sel);

        // write and read errors share one pulse
        sel_bad = (wr_go & ~wr_ok) | (rd_go & ~rd_ok);
    end

    // --------------------
    // downlink write port
    // --------------------
    always_comb
    begin
        // shared by all six downlink buffers, bit 10 forced low
        o_dn_wr.wren = wr_ok;
        o_dn_wr.addr = buf_addr_t'(i_cb_wr.addr.offset);
        o_dn_wr.data = i_cb_wr.data;

        // per-buffer enable, only the selected channel
        o_dn_wsel    = wr_ok ? i_cb_wr.addr.ch_sel : '0;
    end

    // uplink read address to all six buffers, upper half unreachable
    assign o_up_raddr = buf_addr_t'(i_cb_rd.addr.offset);

    // --------------------
    // read select pipeline
    // --------------------
    always_ff @(posedge sys_clk_50m or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int s = 0; s < RD_LAT; s++)
            begin
                rd_sel_q[s] <= '0;
                rd_vld_q[s] <= 1'b0;
            end
            o_cb_rvalid <= 1'b0;
            o_sel_err   <= 1'b0;
        end
        else
        begin
            // stage 0 follows the buffer addr register
            rd_sel_q[0] <= rd_ok ? i_cb_rd.addr.ch_sel : '0;
            rd_vld_q[0] <= rd_ok;
            for (int s = 1; s < RD_LAT; s++)
            begin
                rd_sel_q[s] <= rd_sel_q[s-1];
                rd_vld_q[s] <= rd_vld_q[s-1];
            end

            // valid lines up with the mux output register
            o_cb_rvalid <= rd_vld_q[RD_LAT-1];
            o_sel_err   <= sel_bad;
        end
    end

    // select reaches the mux together with the buffer data register
    assign o_rd_sel = rd_sel_q[RD_LAT-1];

endmodule

`default_nettype wire

// ==== logic/chan_buf_ram.sv ====
// channel buffer, 2048 x 8
// one write port and one read port on the same clock;
// read address and read data are both registered,
// so data shows up two cycles after the address
`default_nettype none

module chan_buf_ram
(
    input  wire                              sys_clk_50m,
    input  wire buf_exchange_pkg::buf_wr_t   i_wr,
    input  wire buf_exchange_pkg::buf_addr_t i_raddr,
    output buf_exchange_pkg::byte_t          o_rdata
);

    import buf_exchange_pkg::*;

    // --------------------
    // storage
    // --------------------
    byte_t     mem [2**BUF_ADDR_W];

    // registered read address
    buf_addr_t raddr_q;

    // write port
    // takes effect at the next edge
    always_ff @(posedge sys_clk_50m)
    begin
        if (i_wr.wren)
        begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // --------------------
    // read port
    // --------------------
    // cycle 1, capture the address
    always_ff @(posedge sys_clk_50m)
    begin
        raddr_q <= i_raddr;
    end

    // cycle 2, data register
    // c-bus path counts this as its second stage
    always_ff @(posedge sys_clk_50m)
    begin
        o_rdata <= mem[raddr_q];
    end

endmodule

`default_nettype wire

// ==== logic/cbus_rdata_mux.sv ====
// c-bus read data mux
// picks the uplink byte of the channel named by the delayed one-hot
// read select and registers it onto the c-bus.
// an empty select leaves the last byte in place
`default_nettype none

module cbus_rdata_mux
(
    input  wire                              sys_clk_50m,
    input  wire                              i_rst_n,
    input  wire buf_exchange_pkg::ch_sel_t   i_rd_sel,
    input  wire buf_exchange_pkg::byte_t     i_up_rdata [buf_exchange_pkg::NUM_CH],
    output buf_exchange_pkg::byte_t          o_cb_rdata
);

    import buf_exchange_pkg::*;

    // selected byte, before the output register
    byte_t rdata_nxt;
    // some channel selected this cycle
    logic  sel_hit;

    // --------------------
    // one-hot select
    // --------------------
    always_comb
    begin
        rdata_nxt = '0;
        sel_hit   = 1'b0;
        // select is clean one-hot or empty from the controller
        for (int k = 0; k < NUM_CH; k++)
        begin
            if (i_rd_sel[k])
            begin
                rdata_nxt = i_up_rdata[k];
                sel_hit   = 1'b1;
            end
        end
    end

    // --------------------
    // output register
    // --------------------
    // last stage of the c-bus read, RAM data reg feeds it directly
    always_ff @(posedge sys_clk_50m or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_cb_rdata <= '0;
        end
        else if (sel_hit)
        begin
            o_cb_rdata <= rdata_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/buf_exchange_top.sv ====
// buffer exchange top
// connects the c-bus to six C-Link channels through a pair of
// 2048 x 8 buffers per channel:
//   downlink, written by the c-bus and read by the channel
//   uplink, written by the channel and read back over the c-bus
// c-bus side is gated by init done, channel side is not
`default_nettype none

module buf_exchange_top
(
    input  wire                              sys_clk_50m,
    input  wire                              i_rst_n,
    input  wire                              i_init_done,

    // --------------------
    // c-bus side
    // --------------------
    input  wire buf_exchange_pkg::cb_wr_t    i_cb_wr,
    input  wire buf_exchange_pkg::cb_rd_t    i_cb_rd,
    output wire buf_exchange_pkg::byte_t     o_cb_rdata,
    output wire                              o_cb_rvalid,
    output wire                              o_sel_err,

    // --------------------
    // channel side
    // --------------------
    // uplink write per channel
    input  wire buf_exchange_pkg::buf_wr_t   i_ch_up [buf_exchange_pkg::NUM_CH],
    // downlink read per channel
    input  wire buf_exchange_pkg::buf_addr_t i_ch_dn_raddr [buf_exchange_pkg::NUM_CH],
    output wire buf_exchange_pkg::byte_t     o_ch_dn_rdata [buf_exchange_pkg::NUM_CH]
);

    import buf_exchange_pkg::*;

    // shared downlink write port and per-channel enables
    wire buf_wr_t   dn_wr;
    wire ch_sel_t   dn_wsel;

    // shared uplink read address
    wire buf_addr_t up_raddr;

    // delayed read select into the mux
    wire ch_sel_t   rd_sel;

    // uplink read bytes, one per channel
    wire byte_t     up_rdata [NUM_CH];

    // --------------------
    // c-bus control
    // --------------------
    cbus_buf_ctrl u_cbus_buf_ctrl
    (
        .sys_clk_50m (sys_clk_50m),
        .i_rst_n     (i_rst_n),
        .i_init_done (i_init_done),
        .i_cb_wr     (i_cb_wr),
        .i_cb_rd     (i_cb_rd),
        .o_dn_wr     (dn_wr),
        .o_dn_wsel   (dn_wsel),
        .o_up_raddr  (up_raddr),
        .o_rd_sel    (rd_sel),
        .o_cb_rvalid (o_cb_rvalid),
        .o_sel_err   (o_sel_err)
    );

    // --------------------
    // channel buffers
    // --------------------
    for (genvar k = 0; k < NUM_CH; k++)
    begin : g_chan
        // downlink write port of this channel
        wire buf_wr_t dn_wr_k;

        // only the selected channel sees the write strobe
        assign dn_wr_k = '{
            wren: dn_wr.wren & dn_wsel[k],
            addr: dn_wr.addr,
            data: dn_wr.data
        };

        // c-bus writes, channel reads
        chan_buf_ram u_dn_buf
        (
            .sys_clk_50m (sys_clk_50m),
            .i_wr        (dn_wr_k),
            .i_raddr     (i_ch_dn_raddr[k]),
            .o_rdata     (o_ch_dn_rdata[k])
        );

        // channel writes, c-bus reads
        chan_buf_ram u_up_buf
        (
            .sys_clk_50m (sys_clk_50m),
            .i_wr        (i_ch_up[k]),
            .i_raddr     (up_raddr),
            .o_rdata     (up_rdata[k])
        );
    end

    // --------------------
    // c-bus read back
    // --------------------
    cbus_rdata_mux u_cbus_rdata_mux
    (
        .sys_clk_50m (sys_clk_50m),
        .i_rst_n     (i_rst_n),
        .i_rd_sel    (rd_sel),
        .i_up_rdata  (up_rdata),
        .o_cb_rdata  (o_cb_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
// testbench clock and reset
// 50 MHz clock, active-low reset held for the first 16 cycles
`default_nettype none

module tb_clk_gen
(
    output logic o_sys_clk_50m,
    output logic o_rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // half of the 20 ns period
    localparam int HALF_NS    = 10;
    localparam int RST_CYCLES = 16;

    initial
    begin
        o_sys_clk_50m = 1'b0;
        forever
        begin
            #HALF_NS o_sys_clk_50m = ~o_sys_clk_50m;
        end
    end

    // released on a falling edge, like every other input
    initial
    begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(negedge o_sys_clk_50m);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/buf_exchange_tb.sv ====
// buffer exchange testbench
// drives the c-bus and the six channel ports on the falling edge and
// checks every read against shadow copies of the twelve buffers
`default_nettype none

module buf_exchange_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import buf_exchange_pkg::*;

    localparam int unsigned SEED = 32'hc49c330a;

    wire            sys_clk_50m;
    wire            i_rst_n;
    logic           i_init_done;
    cb_wr_t         i_cb_wr;
    cb_rd_t         i_cb_rd;
    buf_wr_t        i_ch_up [NUM_CH];
    buf_addr_t      i_ch_dn_raddr [NUM_CH];
    wire byte_t     o_cb_rdata;
    wire            o_cb_rvalid;
    wire            o_sel_err;
    wire byte_t     o_ch_dn_rdata [NUM_CH];

    // stimulus for the next cycle, applied by apply_cycle
    logic           nxt_init;
    cb_wr_t         nxt_wr;
    cb_rd_t         nxt_rd;
    buf_wr_t        nxt_up [NUM_CH];
    buf_addr_t      nxt_dn_ra [NUM_CH];

    // shadow buffers
    byte_t          shadow_dn [NUM_CH][2048];
    byte_t          shadow_up [NUM_CH][2048];

    // expected results of the cycle just driven
    logic           exp_err = 1'b0;
    logic           exp_rv = 1'b0;
    byte_t          exp_rdata = '0;
    byte_t          exp_dn [NUM_CH];
    logic           exp_dn_chk = 1'b0;
    logic           dn_chk_en = 1'b0;

    // --------------------
    // comparing process state
    // --------------------
    logic           chk_en = 1'b0;
    logic           err_q;
    logic           rv_q [3];
    byte_t          rd_q [3];
    byte_t          dn_q [2][NUM_CH];
    logic           dn_chk_q [2];
    string          test_name = "reset";
    string          name_q = "reset";

    int             n_data_err = 0;
    int             n_pulse_err = 0;
    int             n_timeout = 0;

    tb_clk_gen u_clk_gen
    (
        .o_sys_clk_50m (sys_clk_50m),
        .o_rst_n       (i_rst_n)
    );

    buf_exchange_top UUT
    (
        .sys_clk_50m   (sys_clk_50m),
        .i_rst_n       (i_rst_n),
        .i_init_done   (i_init_done),
        .i_cb_wr       (i_cb_wr),
        .i_cb_rd       (i_cb_rd),
        .o_cb_rdata    (o_cb_rdata),
        .o_cb_rvalid   (o_cb_rvalid),
        .o_sel_err     (o_sel_err),
        .i_ch_up       (i_ch_up),
        .i_ch_dn_raddr (i_ch_dn_raddr),
        .o_ch_dn_rdata (o_ch_dn_rdata)
    );

    task automatic check_byte(input string what, input byte_t exp, input byte_t act);
        if (act !== exp)
        begin
            n_data_err++;
            $display("Fail %s %s: expected %02h, actual %02h", name_q, what, exp, act);
        end
    endtask

    task automatic check_pulse(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            n_pulse_err++;
            $display("Fail %s %s: expected %b, actual %b", name_q, what, exp, act);
        end
    endtask

    // channel of a one-hot select, -1 for none or several
    function automatic int sel_to_ch(input ch_sel_t sel);
        int ch;
        ch = -1;
        for (int k = 0; k < NUM_CH; k++)
        begin
            if (sel[k])
            begin
                ch = (ch == -1) ? k : -2;
            end
        end
        return (ch < 0) ? -1 : ch;
    endfunction

    // expected c-bus read byte, holds the last one without a clean select
    function automatic byte_t ref_rdata(input logic go, input cb_addr_t a, input byte_t last);
        int ch;
        ch = sel_to_ch(a.ch_sel);
        if (!go || ch < 0)
            return last;
        return shadow_up[ch][{1'b0, a.offset}];
    endfunction

    // fill pattern, every address bit moves the byte
    function automatic byte_t fill_byte(input int buf_no, input int a);
        return byte_t'((a * 7) ^ (a >> 8) ^ (buf_no * 59));
    endfunction

    // mostly one-hot, now and then empty or several bits
    function automatic ch_sel_t rand_sel();
        int r;
        r = $urandom % 16;
        if (r == 0)
            return '0;
        if (r == 1)
            return ch_sel_t'($urandom) | ch_sel_t'(3);
        return ch_sel_t'(1) << ($urandom % NUM_CH);
    endfunction

    task automatic cb_write(input ch_sel_t sel, input logic [9:0] ofs, input byte_t data);
        nxt_wr.wren        = 1'b1;
        nxt_wr.addr.ch_sel = sel;
        nxt_wr.addr.offset = ofs;
        nxt_wr.data        = data;
    endtask

    task automatic cb_read(input ch_sel_t sel, input logic [9:0] ofs);
        nxt_rd.rden        = 1'b1;
        nxt_rd.addr.ch_sel = sel;
        nxt_rd.addr.offset = ofs;
    endtask

    task automatic ch_write(input int k, input buf_addr_t addr, input byte_t data);
        nxt_up[k].wren = 1'b1;
        nxt_up[k].addr = addr;
        nxt_up[k].data = data;
    endtask

    // --------------------
    // one clock of stimulus
    // --------------------
    task automatic apply_cycle();
        int   ch;
        logic wgo;
        logic rgo;
        @(negedge sys_clk_50m);
        i_init_done   = nxt_init;
        i_cb_wr       = nxt_wr;
        i_cb_rd       = nxt_rd;
        i_ch_up       = nxt_up;
        i_ch_dn_raddr = nxt_dn_ra;
        // writes landing at the coming rising edge
        wgo = nxt_init & nxt_wr.wren;
        rgo = nxt_init & nxt_rd.rden;
        ch  = sel_to_ch(nxt_wr.addr.ch_sel);
        if (wgo && ch >= 0)
            shadow_dn[ch][{1'b0, nxt_wr.addr.offset}] = nxt_wr.data;
        for (int k = 0; k < NUM_CH; k++)
        begin
            if (nxt_up[k].wren)
                shadow_up[k][nxt_up[k].addr] = nxt_up[k].data;
            exp_dn[k] = shadow_dn[k][nxt_dn_ra[k]];
            nxt_up[k].wren = 1'b0;
        end
        // a read sees writes of its own cycle
        exp_err    = (wgo && ch < 0) || (rgo && sel_to_ch(nxt_rd.addr.ch_sel) < 0);
        exp_rv     = rgo && sel_to_ch(nxt_rd.addr.ch_sel) >= 0;
        exp_rdata  = ref_rdata(rgo, nxt_rd.addr, exp_rdata);
        exp_dn_chk = dn_chk_en;
        nxt_wr.wren = 1'b0;
        nxt_rd.rden = 1'b0;
    endtask

    task automatic wait_reset(input int max_cyc);
        int n;
        n = 0;
        while (i_rst_n !== 1'b1)
        begin
            if (n == max_cyc)
            begin
                n_timeout++;
                $display("timeout: reset was not released after %0d cycles", max_cyc);
                return;
            end
            @(posedge sys_clk_50m);
            n++;
        end
    endtask

    task automatic wait_rvalid(input int max_cyc);
        int n;
        n = 0;
        while (o_cb_rvalid !== 1'b1)
        begin
            if (n == max_cyc)
            begin
                n_timeout++;
                $display("timeout: no read valid within %0d cycles", max_cyc);
                return;
            end
            apply_cycle();
            n++;
        end
    endtask

    // expectations ride along with the DUT pipeline
    always @(posedge sys_clk_50m)
    begin
        chk_en      <= i_rst_n;
        name_q      <= test_name;
        err_q       <= exp_err;
        rv_q[0]     <= exp_rv;
        rd_q[0]     <= exp_rdata;
        dn_chk_q[0] <= exp_dn_chk;
        dn_chk_q[1] <= dn_chk_q[0];
        for (int s = 1; s < 3; s++)
        begin
            rv_q[s] <= rv_q[s-1];
            rd_q[s] <= rd_q[s-1];
        end
        for (int k = 0; k < NUM_CH; k++)
        begin
            dn_q[0][k] <= exp_dn[k];
            dn_q[1][k] <= dn_q[0][k];
        end
    end

    // outputs are settled at the falling edge
    always @(negedge sys_clk_50m)
    begin
        if (chk_en)
        begin
            check_pulse("sel_err", err_q, o_sel_err);
            check_pulse("cb_rvalid", rv_q[2], o_cb_rvalid);
            check_byte("cb_rdata", rd_q[2], o_cb_rdata);
            for (int k = 0; k < NUM_CH; k++)
            begin
                if (dn_chk_q[1])
                    check_byte("dn_rdata", dn_q[1][k], o_ch_dn_rdata[k]);
            end
        end
    end

    initial
    begin
        logic [9:0] m;
        logic [9:0] m_list [12];
        void'($urandom(SEED));
        nxt_init = 1'b0;
        nxt_wr   = '0;
        nxt_rd   = '0;
        for (int k = 0; k < NUM_CH; k++)
        begin
            nxt_up[k]    = '0;
            nxt_dn_ra[k] = '0;
            exp_dn[k]    = '0;
        end
        i_init_done   = 1'b0;
        i_cb_wr       = '0;
        i_cb_rd       = '0;
        i_ch_up       = nxt_up;
        i_ch_dn_raddr = nxt_dn_ra;

        wait_reset(40);
        apply_cycle();
        check_pulse("reset rvalid", 1'b0, o_cb_rvalid);
        check_pulse("reset sel_err", 1'b0, o_sel_err);
        check_byte("reset rdata", '0, o_cb_rdata);

        // preload lower downlink halves over the c-bus, all uplinks from the channels
        test_name = "fill";
        nxt_init  = 1'b1;
        for (int i = 0; i < NUM_CH * 1024; i++)
        begin
            for (int k = 0; k < NUM_CH && i < 2048; k++)
                ch_write(k, buf_addr_t'(i), fill_byte(k + NUM_CH, i));
            cb_write(ch_sel_t'(1) << (i / 1024), 10'(i % 1024), fill_byte(i / 1024, i % 1024));
            apply_cycle();
        end

        // --------------------
        // downlink, all six channels read the written offset
        // --------------------
        test_name = "downlink";
        dn_chk_en = 1'b1;
        for (int t = 0; t < 12; t++)
        begin
            m = 10'($urandom);
            for (int k = 0; k < NUM_CH; k++)
                nxt_dn_ra[k] = {1'b0, m};
            cb_write(ch_sel_t'(1) << (t % NUM_CH), m, byte_t'($urandom));
            repeat (4) apply_cycle();
        end

        test_name = "uplink";
        for (int k = 0; k < NUM_CH; k++)
        begin
            m = 10'($urandom);
            ch_write(k, {1'b0, m}, byte_t'($urandom));
            apply_cycle();
            cb_read(ch_sel_t'(1) << k, m);
            apply_cycle();
            wait_rvalid(5);
        end
        test_name = "back to back";
        for (int i = 0; i < 8; i++)
        begin
            cb_read(ch_sel_t'(1) << (i % NUM_CH), 10'($urandom));
            apply_cycle();
        end
        repeat (4) apply_cycle();

        // zero select on every third, several bits otherwise
        test_name = "bad select";
        for (int i = 0; i < 8; i++)
        begin
            m = 10'($urandom);
            for (int k = 0; k < NUM_CH; k++)
                nxt_dn_ra[k] = {1'b0, m};
            if (i < 4)
                cb_write((i % 3 == 0) ? '0 : ch_sel_t'($urandom) | ch_sel_t'(3), m, 8'hff);
            else
                cb_read((i % 3 == 0) ? '0 : ch_sel_t'($urandom) | ch_sel_t'(5), m);
            repeat (4) apply_cycle();
        end

        // --------------------
        // init low, channel side still live
        // --------------------
        test_name = "init gating";
        nxt_init  = 1'b0;
        for (int i = 0; i < 12; i++)
        begin
            m         = 10'($urandom);
            m_list[i] = m;
            for (int k = 0; k < NUM_CH; k++)
                nxt_dn_ra[k] = {1'b0, m};
            cb_write(ch_sel_t'(1) << (i % NUM_CH), m, byte_t'($urandom));
            cb_read((i % 2 == 0) ? '0 : ch_sel_t'(1) << (i % NUM_CH), m);
            ch_write(i % NUM_CH, {1'b0, m}, byte_t'($urandom));
            repeat (2) apply_cycle();
        end
        nxt_init = 1'b1;
        for (int i = 0; i < 12; i++)
        begin
            cb_read(ch_sel_t'(1) << (i % NUM_CH), m_list[i]);
            apply_cycle();
        end

        // small offset range so writes and reads collide often
        test_name = "random mix";
        for (int i = 0; i < 400; i++)
        begin
            if ($urandom % 3 == 0)
                cb_write(rand_sel(), 10'($urandom % 32), byte_t'($urandom));
            if ($urandom % 2 == 0)
                cb_read(rand_sel(), 10'($urandom % 32));
            for (int k = 0; k < NUM_CH; k++)
            begin
                if ($urandom % 4 == 0)
                    ch_write(k, {1'($urandom), 10'($urandom % 32)}, byte_t'($urandom));
                nxt_dn_ra[k] = {1'b0, 10'($urandom % 32)};
            end
            apply_cycle();
        end
        repeat (4) apply_cycle();

        $display("errors: data %0d, pulse %0d, timeout %0d", n_data_err, n_pulse_err, n_timeout);
        if (n_data_err + n_pulse_err + n_timeout == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/buf_exchange_pkg.sv
logic/cbus_buf_ctrl.sv
logic/chan_buf_ram.sv
logic/cbus_rdata_mux.sv
logic/buf_exchange_top.sv
tb/tb_clk_gen.sv
tb/buf_exchange_tb.sv

// ==== Makefile ====
# Verilator build and run of the buffer exchange testbench

SIM      = verilator
TOP      = buf_exchange_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal -j 0

.PHONY: simulate clean

# build, run, then look for the pass line in the output
simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
